//--- Makefile
TOP = dispatchTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o simv
	@out=$$(./obj_dir/simv); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

//--- build.f
verilog/dispatchPkg.sv
verilog/loadStoreClassifier.sv
verilog/renameBundleBuffer.sv
verilog/dispatchAllocator.sv
verilog/dispatchTop.sv
test/dispatch_checker.sv
test/dispatchTb.sv

//--- test/dispatchTb.sv
/* Dispatch stage testbench driving a table of bundles into a scoreboard
   Covers operand decode, queue space limits, mask clearing and back-pressure */
`timescale 1ns/100ps

module dispatchTb;
  import dispatchPkg::*;

  localparam int DISPATCH_WIDTH = 2;
  localparam int ROWS           = 10;
  localparam int TIMEOUT        = 200;
  localparam int LANE_BITS      = 73;

  logic                       clk;
  logic                       rstN;
  logic                       renameValid;
  logic                       renameReady;
  logic [PC_WIDTH-1:0]        pcIn          [DISPATCH_WIDTH];
  logic [INST_TYPE_WIDTH-1:0] instTypeIn    [DISPATCH_WIDTH];
  logic [LOG_REG_WIDTH-1:0]   logDestIn     [DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0]  physDestIn    [DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0]  oldPhysDestIn [DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0]  physSrc1In    [DISPATCH_WIDTH];
  operandU                    operandIn     [DISPATCH_WIDTH];
  logic                       immValidIn    [DISPATCH_WIDTH];
  logic [CHECKPOINTS-1:0]     branchMaskIn  [DISPATCH_WIDTH];
  logic                       ctrlVerified;
  logic [CHECKPOINTS_LOG-1:0] ctrlVerifiedId;
  logic [4:0]                 lqCnt;
  logic [4:0]                 sqCnt;
  logic [5:0]                 iqCnt;
  logic [6:0]                 alCnt;
  logic                       dispatchValid;
  logic                       stallFrontEnd;
  logic [PC_WIDTH-1:0]        pcOut          [DISPATCH_WIDTH];
  logic [LOG_REG_WIDTH-1:0]   logDestOut     [DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0]  physDestOut    [DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0]  oldPhysDestOut [DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0]  physSrc1Out    [DISPATCH_WIDTH];
  logic                       src2ValidOut   [DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0]  src2TagOut     [DISPATCH_WIDTH];
  logic                       immValidOut    [DISPATCH_WIDTH];
  logic [DATA_WIDTH-1:0]      immOut         [DISPATCH_WIDTH];
  logic                       isLoadOut      [DISPATCH_WIDTH];
  logic                       isStoreOut     [DISPATCH_WIDTH];
  logic [CHECKPOINTS-1:0]     branchMaskOut  [DISPATCH_WIDTH];

  logic [2*LANE_BITS-1:0] expQ[$];
  string                  nameQ[$];
  int errCnt     = 0;
  int timeoutCnt = 0;
  int dispCnt    = 0;

  // Lane types, immValid flags and lane 0 mask (lane 1 takes its inverse)
  // followed by lq, sq, iq and al counts and the verify id (-1 for none)
  int tbl [ROWS][10] = '{
    '{0, 1, 0, 1, 3,  0,  0,  0,  0, -1},
    '{2, 3, 1, 0, 5,  0,  0,  0,  0, -1},
    '{0, 0, 0, 0, 1,  0,  0, 30,  0, -1},
    '{0, 2, 1, 1, 6,  0,  0, 31,  0,  1},
    '{1, 0, 0, 1, 2,  0,  0,  0, 62, -1},
    '{3, 0, 1, 0, 15, 0,  0,  0, 63,  2},
    '{2, 2, 0, 0, 9,  15, 0,  0,  0,  0},
    '{2, 0, 1, 0, 4,  15, 0,  0,  0, -1},
    '{3, 3, 0, 1, 8,  0, 15,  0,  0,  3},
    '{3, 1, 0, 0, 7,  0, 15,  0,  0, -1}
  };
  string rowName [ROWS] = '{"passThrough", "loadStore", "iqEdge", "iqFull", "alEdge",
                            "alFull", "lqTwoLoads", "lqOneLoad", "sqTwoStores", "sqOneStore"};

  dispatchTop #(
    .DISPATCH_WIDTH(DISPATCH_WIDTH)
  ) dispatchTop_inst (
    .clk(clk), .rstN_i(rstN),
    .renameValid_i(renameValid), .renameReady_o(renameReady),
    .pc_i(pcIn), .instType_i(instTypeIn), .logDest_i(logDestIn),
    .physDest_i(physDestIn), .oldPhysDest_i(oldPhysDestIn), .physSrc1_i(physSrc1In),
    .operand_i(operandIn), .immValid_i(immValidIn), .branchMask_i(branchMaskIn),
    .ctrlVerified_i(ctrlVerified), .ctrlVerifiedId_i(ctrlVerifiedId),
    .loadQueueCnt_i(lqCnt), .storeQueueCnt_i(sqCnt),
    .issueQueueCnt_i(iqCnt), .activeListCnt_i(alCnt),
    .dispatchValid_o(dispatchValid), .stallFrontEnd_o(stallFrontEnd),
    .pc_o(pcOut), .logDest_o(logDestOut), .physDest_o(physDestOut),
    .oldPhysDest_o(oldPhysDestOut), .physSrc1_o(physSrc1Out),
    .src2Valid_o(src2ValidOut), .src2Tag_o(src2TagOut), .immValid_o(immValidOut),
    .imm_o(immOut), .isLoad_o(isLoadOut), .isStore_o(isStoreOut),
    .branchMask_o(branchMaskOut)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Expected outputs of one driven lane (a negative clearId keeps the whole mask)
  function automatic logic [LANE_BITS-1:0] expectLane(input int lane, input int clearId);
    logic [PHYS_TAG_WIDTH-1:0] word;
    logic [PHYS_TAG_WIDTH-1:0] tagExp;
    logic [DATA_WIDTH-1:0]     immExp;
    logic [CHECKPOINTS-1:0]    mask;
    word   = operandIn[lane].src2Tag;
    tagExp = immValidIn[lane] ? '0 : word;
    immExp = '0;
    if (immValidIn[lane]) begin
      immExp = DATA_WIDTH'($signed(word));
    end
    mask   = branchMaskIn[lane];
    if (clearId >= 0) begin
      mask[clearId] = 1'b0;
    end
    return {pcIn[lane], logDestIn[lane], physDestIn[lane], oldPhysDestIn[lane],
            physSrc1In[lane], !immValidIn[lane], tagExp, immValidIn[lane], immExp,
            instTypeIn[lane] == TYPE_LOAD, instTypeIn[lane] == TYPE_STORE, mask};
  endfunction

  function automatic logic [2*LANE_BITS-1:0] packOutputs();
    logic [2*LANE_BITS-1:0] v;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      v[i*LANE_BITS +: LANE_BITS] = {pcOut[i], logDestOut[i], physDestOut[i],
        oldPhysDestOut[i], physSrc1Out[i], src2ValidOut[i], src2TagOut[i],
        immValidOut[i], immOut[i], isLoadOut[i], isStoreOut[i], branchMaskOut[i]};
    end
    return v;
  endfunction

  function automatic bit needsStall(input int r);
    int loads;
    int stores;
    loads  = (tbl[r][0] == 2) + (tbl[r][1] == 2);
    stores = (tbl[r][0] == 3) + (tbl[r][1] == 3);
    return (tbl[r][5] + loads > 16) || (tbl[r][6] + stores > 16) ||
           (tbl[r][7] + 2 > 32) || (tbl[r][8] + 2 > 64);
  endfunction

  task automatic setCounts(input int lq, input int sq, input int iq, input int al);
    @(posedge clk);
    #1;
    lqCnt = 5'(lq);
    sqCnt = 5'(sq);
    iqCnt = 6'(iq);
    alCnt = 7'(al);
  endtask

  // Drives one bundle, waits for its acceptance and queues the expected outputs
  task automatic sendBundle(input int r, input string name, input int clearId);
    int t;
    logic [2*LANE_BITS-1:0] e;
    @(posedge clk);
    #1;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      pcIn[i]              = PC_WIDTH'($urandom);
      logDestIn[i]         = LOG_REG_WIDTH'($urandom);
      physDestIn[i]        = PHYS_TAG_WIDTH'($urandom);
      oldPhysDestIn[i]     = PHYS_TAG_WIDTH'($urandom);
      physSrc1In[i]        = PHYS_TAG_WIDTH'($urandom);
      operandIn[i].src2Tag = PHYS_TAG_WIDTH'($urandom);
      instTypeIn[i]        = INST_TYPE_WIDTH'(tbl[r][i]);
      immValidIn[i]        = tbl[r][2+i][0];
      branchMaskIn[i]      = (i == 0) ? CHECKPOINTS'(tbl[r][4]) : ~CHECKPOINTS'(tbl[r][4]);
      e[i*LANE_BITS +: LANE_BITS] = expectLane(i, clearId);
    end
    renameValid = 1'b1;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!renameReady && t < TIMEOUT);
    if (!renameReady) begin
      timeoutCnt++;
      $display("Timed out waiting for rename ready in %s", name);
    end
    expQ.push_back(e);
    nameQ.push_back(name);
    @(posedge clk);
    #1;
    renameValid = 1'b0;
  endtask

  task automatic waitDispatches(input int target, input string name);
    int t;
    t = 0;
    while (dispCnt < target && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (dispCnt < target) begin
      timeoutCnt++;
      $display("Timed out waiting for dispatch in %s", name);
    end
  endtask

  // Scoreboard samples on the falling edge
  always @(negedge clk) begin
    if (rstN && dispatchValid) begin
      assert (expQ.size() != 0) else begin
        errCnt++;
        $display("Dispatch seen with no bundle outstanding");
      end
      if (expQ.size() != 0) begin
        assert (packOutputs() == expQ[0]) else begin
          errCnt++;
          $display("[FAIL] %s expected %h actual %h", nameQ[0], expQ[0], packOutputs());
        end
        void'(expQ.pop_front());
        void'(nameQ.pop_front());
      end
      dispCnt++;
    end
  end

  initial begin
    int base;
    bit stall;
    void'($urandom(32'h6095b07f));
    rstN           = 1'b0;
    renameValid    = 1'b0;
    ctrlVerified   = 1'b0;
    ctrlVerifiedId = '0;
    lqCnt          = '0;
    sqCnt          = '0;
    iqCnt          = '0;
    alCnt          = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      pcIn[i]          = '0;
      instTypeIn[i]    = '0;
      logDestIn[i]     = '0;
      physDestIn[i]    = '0;
      oldPhysDestIn[i] = '0;
      physSrc1In[i]    = '0;
      operandIn[i]     = '0;
      immValidIn[i]    = 1'b0;
      branchMaskIn[i]  = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;

    for (int r = 0; r < ROWS; r++) begin
      stall = needsStall(r);
      base  = dispCnt;
      setCounts(tbl[r][5], tbl[r][6], tbl[r][7], tbl[r][8]);
      sendBundle(r, rowName[r], stall ? tbl[r][9] : -1);
      if (stall) begin
        repeat (3) begin
          @(negedge clk);
          assert (stallFrontEnd) else begin
            errCnt++;
            $display("[FAIL] %s stallFrontEnd_o expected 1 actual %0b", rowName[r],
                     stallFrontEnd);
          end
          assert (!dispatchValid) else begin
            errCnt++;
            $display("[FAIL] %s dispatchValid_o expected 0 actual 1", rowName[r]);
          end
        end
        if (tbl[r][9] >= 0) begin
          @(posedge clk);
          #1;
          ctrlVerified   = 1'b1;
          ctrlVerifiedId = CHECKPOINTS_LOG'(tbl[r][9]);
          @(posedge clk);
          #1;
          ctrlVerified   = 1'b0;
        end
        setCounts(0, 0, 0, 0);  // Release the held bundle
      end else begin
        @(negedge clk);
        assert (!stallFrontEnd) else begin
          errCnt++;
          $display("[FAIL] %s stallFrontEnd_o expected 0 actual 1", rowName[r]);
        end
      end
      waitDispatches(base + 1, rowName[r]);
    end

    // Three bundles arrive while the issue queue is full
    base = dispCnt;
    setCounts(0, 0, 32, 0);
    sendBundle(0, "backPressure0", -1);
    sendBundle(1, "backPressure1", -1);
    @(negedge clk);
    assert (!renameReady) else begin
      errCnt++;
      $display("[FAIL] backPressure renameReady_o expected 0 actual %0b", renameReady);
    end
    fork
      sendBundle(2, "backPressure2", -1);
      begin
        repeat (3) @(negedge clk);
        setCounts(0, 0, 0, 0);  // Release while the third bundle waits
      end
    join
    waitDispatches(base + 3, "backPressure");
    repeat (5) @(negedge clk);
    assert (expQ.size() == 0) else begin
      errCnt++;
      $display("Bundles never dispatched: %0d", expQ.size());
    end

    $display("Errors: %0d check failures, %0d timeouts", errCnt, timeoutCnt);
    if (errCnt == 0 && timeoutCnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- test/dispatch_checker.sv
/* Dispatch stage checker, bound to the top level
   Reset outputs, load/store exclusivity and rename hold rules */
`timescale 1ns/100ps

module dispatchChecker #(
  parameter int DISPATCH_WIDTH = 2
) (
  input logic                                    clk,
  input logic                                    rstN_i,
  input logic                                    renameValid_i,
  input logic                                    renameReady_o,
  input logic [dispatchPkg::PC_WIDTH-1:0]        pc_i       [DISPATCH_WIDTH],
  input logic [dispatchPkg::INST_TYPE_WIDTH-1:0] instType_i [DISPATCH_WIDTH],
  input logic [dispatchPkg::LOG_REG_WIDTH-1:0]   logDest_i  [DISPATCH_WIDTH],
  input logic                                    dispatchValid_o,
  input logic                                    stallFrontEnd_o,
  input logic                                    isLoad_o   [DISPATCH_WIDTH],
  input logic                                    isStore_o  [DISPATCH_WIDTH]
);

  assert property (@(posedge clk) !rstN_i |=> !dispatchValid_o && !stallFrontEnd_o)
    else $error("Dispatch outputs active during reset");

  for (genvar i = 0; i < DISPATCH_WIDTH; i++) begin : gLane
    assert property (@(posedge clk) disable iff (!rstN_i)
      dispatchValid_o |-> !(isLoad_o[i] && isStore_o[i]))
      else $error("Lane %0d dispatched as both load and store", i);

    // Rename holds the bundle until it is taken
    assert property (@(posedge clk) disable iff (!rstN_i)
      renameValid_i && !renameReady_o |=> renameValid_i && $stable(pc_i[i])
        && $stable(instType_i[i]) && $stable(logDest_i[i]))
      else $error("Lane %0d rename bundle changed while stalled", i);
  end

endmodule

bind dispatchTop dispatchChecker #(.DISPATCH_WIDTH(DISPATCH_WIDTH)) dispatchChecker_inst (.*);

//--- verilog/dispatchAllocator.sv
/* Dispatch allocator, checks back-end queue space for the head bundle
   and registers the issue queue, active list and LSQ fields */
`timescale 1ns/100ps

module dispatchAllocator #(
  parameter int DISPATCH_WIDTH = 2,
  parameter int LSQ_SIZE       = 16,
  parameter int IQ_SIZE        = 32,
  parameter int AL_SIZE        = 64
) (
  input  logic                                   clk,
  input  logic                                   rstN_i,
  input  logic                                   headValid_i,
  output logic                                   headReady_o,
  input  logic [dispatchPkg::PC_WIDTH-1:0]       pc_i          [DISPATCH_WIDTH],
  input  logic [dispatchPkg::LOG_REG_WIDTH-1:0]  logDest_i     [DISPATCH_WIDTH],
  input  logic [dispatchPkg::PHYS_TAG_WIDTH-1:0] physDest_i    [DISPATCH_WIDTH],
  input  logic [dispatchPkg::PHYS_TAG_WIDTH-1:0] oldPhysDest_i [DISPATCH_WIDTH],
  input  logic [dispatchPkg::PHYS_TAG_WIDTH-1:0] physSrc1_i    [DISPATCH_WIDTH],
  input  dispatchPkg::operandU                   operand_i     [DISPATCH_WIDTH],
  input  logic                                   immValid_i    [DISPATCH_WIDTH],
  input  logic [dispatchPkg::CHECKPOINTS-1:0]    branchMask_i  [DISPATCH_WIDTH],
  input  logic                                   isLoad_i      [DISPATCH_WIDTH],
  input  logic                                   isStore_i     [DISPATCH_WIDTH],
  input  logic [$clog2(DISPATCH_WIDTH+1)-1:0]    loadCnt_i,
  input  logic [$clog2(DISPATCH_WIDTH+1)-1:0]    storeCnt_i,
  input  logic [$clog2(LSQ_SIZE+1)-1:0]          loadQueueCnt_i,
  input  logic [$clog2(LSQ_SIZE+1)-1:0]          storeQueueCnt_i,
  input  logic [$clog2(IQ_SIZE+1)-1:0]           issueQueueCnt_i,
  input  logic [$clog2(AL_SIZE+1)-1:0]           activeListCnt_i,
  output logic                                   dispatchValid_o,
  output logic                                   stallFrontEnd_o,
  output logic [dispatchPkg::PC_WIDTH-1:0]       pc_o          [DISPATCH_WIDTH],
  output logic [dispatchPkg::LOG_REG_WIDTH-1:0]  logDest_o     [DISPATCH_WIDTH],
  output logic [dispatchPkg::PHYS_TAG_WIDTH-1:0] physDest_o    [DISPATCH_WIDTH],
  output logic [dispatchPkg::PHYS_TAG_WIDTH-1:0] oldPhysDest_o [DISPATCH_WIDTH],
  output logic [dispatchPkg::PHYS_TAG_WIDTH-1:0] physSrc1_o    [DISPATCH_WIDTH],
  output logic                                   src2Valid_o   [DISPATCH_WIDTH],
  output logic [dispatchPkg::PHYS_TAG_WIDTH-1:0] src2Tag_o     [DISPATCH_WIDTH],
  output logic                                   immValid_o    [DISPATCH_WIDTH],
  output logic [dispatchPkg::DATA_WIDTH-1:0]     imm_o         [DISPATCH_WIDTH],
  output logic                                   isLoad_o      [DISPATCH_WIDTH],
  output logic                                   isStore_o     [DISPATCH_WIDTH],
  output logic [dispatchPkg::CHECKPOINTS-1:0]    branchMask_o  [DISPATCH_WIDTH]
);
  import dispatchPkg::*;

  logic lqFull;
  logic sqFull;
  logic iqFull;
  logic alFull;
  logic spaceFail;
  logic transfer;

  // Sums widened to 32 bits so occupancy plus demand cannot wrap
  assign lqFull    = (32'(loadQueueCnt_i) + 32'(loadCnt_i)) > LSQ_SIZE;
  assign sqFull    = (32'(storeQueueCnt_i) + 32'(storeCnt_i)) > LSQ_SIZE;
  assign iqFull    = (32'(issueQueueCnt_i) + DISPATCH_WIDTH) > IQ_SIZE;
  assign alFull    = (32'(activeListCnt_i) + DISPATCH_WIDTH) > AL_SIZE;
  assign spaceFail = lqFull | sqFull | iqFull | alFull;

  assign headReady_o     = ~spaceFail;  // Whole bundle or nothing
  assign stallFrontEnd_o = headValid_i & spaceFail;
  assign transfer        = headValid_i & headReady_o;

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      dispatchValid_o <= 1'b0;
    end else begin
      dispatchValid_o <= transfer;  // One cycle per bundle
    end
  end

  always_ff @(posedge clk) begin
    if (transfer) begin
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        pc_o[i]          <= pc_i[i];
        logDest_o[i]     <= logDest_i[i];
        physDest_o[i]    <= physDest_i[i];
        oldPhysDest_o[i] <= oldPhysDest_i[i];
        physSrc1_o[i]    <= physSrc1_i[i];
        immValid_o[i]    <= immValid_i[i];
        isLoad_o[i]      <= isLoad_i[i];
        isStore_o[i]     <= isStore_i[i];
        branchMask_o[i]  <= branchMask_i[i];
        if (immValid_i[i]) begin
          src2Valid_o[i] <= 1'b0;
          src2Tag_o[i]   <= '0;
          imm_o[i]       <= {{(DATA_WIDTH-IMM_WIDTH){operand_i[i].imm[IMM_WIDTH-1]}},
                             operand_i[i].imm};  // Sign extend
        end else begin
          src2Valid_o[i] <= 1'b1;
          src2Tag_o[i]   <= operand_i[i].src2Tag;
          imm_o[i]       <= '0;
        end
      end
    end
  end

endmodule

//--- verilog/dispatchPkg.sv
/* Dispatch stage shared definitions
   Field widths, instruction type codes and the second-operand word */
package dispatchPkg;

  localparam int PC_WIDTH        = 16;
  localparam int LOG_REG_WIDTH   = 5;
  localparam int PHYS_TAG_WIDTH  = 7;
  localparam int IMM_WIDTH       = PHYS_TAG_WIDTH;  // Shares the operand word with the tag
  localparam int DATA_WIDTH      = 16;              // Sign-extended immediate to issue queue
  localparam int CHECKPOINTS     = 4;               // Also the branch mask width
  localparam int CHECKPOINTS_LOG = 2;
  localparam int INST_TYPE_WIDTH = 2;

  localparam logic [INST_TYPE_WIDTH-1:0] TYPE_ALU    = 2'd0;
  localparam logic [INST_TYPE_WIDTH-1:0] TYPE_BRANCH = 2'd1;
  localparam logic [INST_TYPE_WIDTH-1:0] TYPE_LOAD   = 2'd2;
  localparam logic [INST_TYPE_WIDTH-1:0] TYPE_STORE  = 2'd3;

  // Second source operand, a physical tag unless immValid marks an immediate
  typedef union packed {
    logic [PHYS_TAG_WIDTH-1:0] src2Tag;
    logic [IMM_WIDTH-1:0]      imm;
  } operandU;

endpackage

//--- verilog/dispatchTop.sv
/* Dispatch stage top, rename-side classifier feeding the bundle buffer
   and the dispatch allocator */
`timescale 1ns/100ps

module dispatchTop #(
  parameter int DISPATCH_WIDTH = 2,
  parameter int LSQ_SIZE       = 16,
  parameter int IQ_SIZE        = 32,
  parameter int AL_SIZE        = 64
) (
  input  logic                                    clk,
  input  logic                                    rstN_i,
  input  logic                                    renameValid_i,
  output logic                                    renameReady_o,
  input  logic [dispatchPkg::PC_WIDTH-1:0]        pc_i          [DISPATCH_WIDTH],
  input  logic [dispatchPkg::INST_TYPE_WIDTH-1:0] instType_i    [DISPATCH_WIDTH],
  input  logic [dispatchPkg::LOG_REG_WIDTH-1:0]   logDest_i     [DISPATCH_WIDTH],
  input  logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  physDest_i    [DISPATCH_WIDTH],
  input  logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  oldPhysDest_i [DISPATCH_WIDTH],
  input  logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  physSrc1_i    [DISPATCH_WIDTH],
  input  dispatchPkg::operandU                    operand_i     [DISPATCH_WIDTH],
  input  logic                                    immValid_i    [DISPATCH_WIDTH],
  input  logic [dispatchPkg::CHECKPOINTS-1:0]     branchMask_i  [DISPATCH_WIDTH],
  input  logic                                    ctrlVerified_i,
  input  logic [dispatchPkg::CHECKPOINTS_LOG-1:0] ctrlVerifiedId_i,
  input  logic [$clog2(LSQ_SIZE+1)-1:0]           loadQueueCnt_i,
  input  logic [$clog2(LSQ_SIZE+1)-1:0]           storeQueueCnt_i,
  input  logic [$clog2(IQ_SIZE+1)-1:0]            issueQueueCnt_i,
  input  logic [$clog2(AL_SIZE+1)-1:0]            activeListCnt_i,
  output logic                                    dispatchValid_o,
  output logic                                    stallFrontEnd_o,
  output logic [dispatchPkg::PC_WIDTH-1:0]        pc_o          [DISPATCH_WIDTH],
  output logic [dispatchPkg::LOG_REG_WIDTH-1:0]   logDest_o     [DISPATCH_WIDTH],
  output logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  physDest_o    [DISPATCH_WIDTH],
  output logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  oldPhysDest_o [DISPATCH_WIDTH],
  output logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  physSrc1_o    [DISPATCH_WIDTH],
  output logic                                    src2Valid_o   [DISPATCH_WIDTH],
  output logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  src2Tag_o     [DISPATCH_WIDTH],
  output logic                                    immValid_o    [DISPATCH_WIDTH],
  output logic [dispatchPkg::DATA_WIDTH-1:0]      imm_o         [DISPATCH_WIDTH],
  output logic                                    isLoad_o      [DISPATCH_WIDTH],
  output logic                                    isStore_o     [DISPATCH_WIDTH],
  output logic [dispatchPkg::CHECKPOINTS-1:0]     branchMask_o  [DISPATCH_WIDTH]
);
  import dispatchPkg::*;

  localparam int CNT_WIDTH = $clog2(DISPATCH_WIDTH + 1);

  logic                      isLoad          [DISPATCH_WIDTH];  // Rename side
  logic                      isStore         [DISPATCH_WIDTH];
  logic [CNT_WIDTH-1:0]      loadCnt;
  logic [CNT_WIDTH-1:0]      storeCnt;
  logic                      headValid;
  logic                      headReady;
  logic [PC_WIDTH-1:0]       headPc          [DISPATCH_WIDTH];  // Buffer head
  logic [LOG_REG_WIDTH-1:0]  headLogDest     [DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0] headPhysDest    [DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0] headOldPhysDest [DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0] headPhysSrc1    [DISPATCH_WIDTH];
  operandU                   headOperand     [DISPATCH_WIDTH];
  logic                      headImmValid    [DISPATCH_WIDTH];
  logic [CHECKPOINTS-1:0]    headBranchMask  [DISPATCH_WIDTH];
  logic                      headIsLoad      [DISPATCH_WIDTH];
  logic                      headIsStore     [DISPATCH_WIDTH];
  logic [CNT_WIDTH-1:0]      headLoadCnt;
  logic [CNT_WIDTH-1:0]      headStoreCnt;

  loadStoreClassifier #(
    .DISPATCH_WIDTH(DISPATCH_WIDTH)
  ) loadStoreClassifier_inst (
    .instType_i(instType_i),
    .isLoad_o  (isLoad),
    .isStore_o (isStore),
    .loadCnt_o (loadCnt),
    .storeCnt_o(storeCnt)
  );

  renameBundleBuffer #(
    .DISPATCH_WIDTH(DISPATCH_WIDTH)
  ) renameBundleBuffer_inst (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .inValid_i       (renameValid_i),
    .inReady_o       (renameReady_o),
    .pc_i            (pc_i),
    .logDest_i       (logDest_i),
    .physDest_i      (physDest_i),
    .oldPhysDest_i   (oldPhysDest_i),
    .physSrc1_i      (physSrc1_i),
    .operand_i       (operand_i),
    .immValid_i      (immValid_i),
    .branchMask_i    (branchMask_i),
    .isLoad_i        (isLoad),
    .isStore_i       (isStore),
    .loadCnt_i       (loadCnt),
    .storeCnt_i      (storeCnt),
    .ctrlVerified_i  (ctrlVerified_i),
    .ctrlVerifiedId_i(ctrlVerifiedId_i),
    .outValid_o      (headValid),
    .outReady_i      (headReady),
    .pc_o            (headPc),
    .logDest_o       (headLogDest),
    .physDest_o      (headPhysDest),
    .oldPhysDest_o   (headOldPhysDest),
    .physSrc1_o      (headPhysSrc1),
    .operand_o       (headOperand),
    .immValid_o      (headImmValid),
    .branchMask_o    (headBranchMask),
    .isLoad_o        (headIsLoad),
    .isStore_o       (headIsStore),
    .loadCnt_o       (headLoadCnt),
    .storeCnt_o      (headStoreCnt)
  );

  dispatchAllocator #(
    .DISPATCH_WIDTH(DISPATCH_WIDTH),
    .LSQ_SIZE      (LSQ_SIZE),
    .IQ_SIZE       (IQ_SIZE),
    .AL_SIZE       (AL_SIZE)
  ) dispatchAllocator_inst (
    .clk            (clk),
    .rstN_i         (rstN_i),
    .headValid_i    (headValid),
    .headReady_o    (headReady),
    .pc_i           (headPc),
    .logDest_i      (headLogDest),
    .physDest_i     (headPhysDest),
    .oldPhysDest_i  (headOldPhysDest),
    .physSrc1_i     (headPhysSrc1),
    .operand_i      (headOperand),
    .immValid_i     (headImmValid),
    .branchMask_i   (headBranchMask),
    .isLoad_i       (headIsLoad),
    .isStore_i      (headIsStore),
    .loadCnt_i      (headLoadCnt),
    .storeCnt_i     (headStoreCnt),
    .loadQueueCnt_i (loadQueueCnt_i),
    .storeQueueCnt_i(storeQueueCnt_i),
    .issueQueueCnt_i(issueQueueCnt_i),
    .activeListCnt_i(activeListCnt_i),
    .dispatchValid_o(dispatchValid_o),
    .stallFrontEnd_o(stallFrontEnd_o),
    .pc_o           (pc_o),
    .logDest_o      (logDest_o),
    .physDest_o     (physDest_o),
    .oldPhysDest_o  (oldPhysDest_o),
    .physSrc1_o     (physSrc1_o),
    .src2Valid_o    (src2Valid_o),
    .src2Tag_o      (src2Tag_o),
    .immValid_o     (immValid_o),
    .imm_o          (imm_o),
    .isLoad_o       (isLoad_o),
    .isStore_o      (isStore_o),
    .branchMask_o   (branchMask_o)
  );

endmodule

//--- verilog/loadStoreClassifier.sv
/* Load/store classifier on the rename side
   Flags loads and stores per lane and counts them over the bundle */
`timescale 1ns/100ps

module loadStoreClassifier #(
  parameter int DISPATCH_WIDTH = 2
) (
  input  logic [dispatchPkg::INST_TYPE_WIDTH-1:0] instType_i [DISPATCH_WIDTH],
  output logic                                    isLoad_o   [DISPATCH_WIDTH],
  output logic                                    isStore_o  [DISPATCH_WIDTH],
  output logic [$clog2(DISPATCH_WIDTH+1)-1:0]     loadCnt_o,
  output logic [$clog2(DISPATCH_WIDTH+1)-1:0]     storeCnt_o
);
  import dispatchPkg::*;

  localparam int CNT_WIDTH = $clog2(DISPATCH_WIDTH + 1);

  // Counts are ready before the bundle reaches the space check
  always_comb begin
    loadCnt_o  = '0;
    storeCnt_o = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      isLoad_o[i]  = (instType_i[i] == TYPE_LOAD);
      isStore_o[i] = (instType_i[i] == TYPE_STORE);
      loadCnt_o    = loadCnt_o + CNT_WIDTH'(isLoad_o[i]);
      storeCnt_o   = storeCnt_o + CNT_WIDTH'(isStore_o[i]);
    end
  end

endmodule

//--- verilog/renameBundleBuffer.sv
/* Rename-to-dispatch bundle buffer, a two-entry FIFO of whole bundles
   Branch masks drop verified checkpoints while bundles wait */
`timescale 1ns/100ps

module renameBundleBuffer #(
  parameter int DISPATCH_WIDTH = 2
) (
  input  logic                                    clk,
  input  logic                                    rstN_i,
  input  logic                                    inValid_i,
  output logic                                    inReady_o,
  input  logic [dispatchPkg::PC_WIDTH-1:0]        pc_i          [DISPATCH_WIDTH],
  input  logic [dispatchPkg::LOG_REG_WIDTH-1:0]   logDest_i     [DISPATCH_WIDTH],
  input  logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  physDest_i    [DISPATCH_WIDTH],
  input  logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  oldPhysDest_i [DISPATCH_WIDTH],
  input  logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  physSrc1_i    [DISPATCH_WIDTH],
  input  dispatchPkg::operandU                    operand_i     [DISPATCH_WIDTH],
  input  logic                                    immValid_i    [DISPATCH_WIDTH],
  input  logic [dispatchPkg::CHECKPOINTS-1:0]     branchMask_i  [DISPATCH_WIDTH],
  input  logic                                    isLoad_i      [DISPATCH_WIDTH],
  input  logic                                    isStore_i     [DISPATCH_WIDTH],
  input  logic [$clog2(DISPATCH_WIDTH+1)-1:0]     loadCnt_i,
  input  logic [$clog2(DISPATCH_WIDTH+1)-1:0]     storeCnt_i,
  input  logic                                    ctrlVerified_i,
  input  logic [dispatchPkg::CHECKPOINTS_LOG-1:0] ctrlVerifiedId_i,
  output logic                                    outValid_o,
  input  logic                                    outReady_i,
  output logic [dispatchPkg::PC_WIDTH-1:0]        pc_o          [DISPATCH_WIDTH],
  output logic [dispatchPkg::LOG_REG_WIDTH-1:0]   logDest_o     [DISPATCH_WIDTH],
  output logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  physDest_o    [DISPATCH_WIDTH],
  output logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  oldPhysDest_o [DISPATCH_WIDTH],
  output logic [dispatchPkg::PHYS_TAG_WIDTH-1:0]  physSrc1_o    [DISPATCH_WIDTH],
  output dispatchPkg::operandU                    operand_o     [DISPATCH_WIDTH],
  output logic                                    immValid_o    [DISPATCH_WIDTH],
  output logic [dispatchPkg::CHECKPOINTS-1:0]     branchMask_o  [DISPATCH_WIDTH],
  output logic                                    isLoad_o      [DISPATCH_WIDTH],
  output logic                                    isStore_o     [DISPATCH_WIDTH],
  output logic [$clog2(DISPATCH_WIDTH+1)-1:0]     loadCnt_o,
  output logic [$clog2(DISPATCH_WIDTH+1)-1:0]     storeCnt_o
);
  import dispatchPkg::*;

  localparam int CNT_WIDTH = $clog2(DISPATCH_WIDTH + 1);

  logic [PC_WIDTH-1:0]       pcMem          [2][DISPATCH_WIDTH];
  logic [LOG_REG_WIDTH-1:0]  logDestMem     [2][DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0] physDestMem    [2][DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0] oldPhysDestMem [2][DISPATCH_WIDTH];
  logic [PHYS_TAG_WIDTH-1:0] physSrc1Mem    [2][DISPATCH_WIDTH];
  operandU                   operandMem     [2][DISPATCH_WIDTH];
  logic                      immValidMem    [2][DISPATCH_WIDTH];
  logic [CHECKPOINTS-1:0]    branchMaskMem  [2][DISPATCH_WIDTH];
  logic                      isLoadMem      [2][DISPATCH_WIDTH];
  logic                      isStoreMem     [2][DISPATCH_WIDTH];
  logic [CNT_WIDTH-1:0]      loadCntMem     [2];
  logic [CNT_WIDTH-1:0]      storeCntMem    [2];

  logic                   wrPtr;
  logic                   rdPtr;
  logic [1:0]             count;     // Bundles held, 0 to 2
  logic                   push;
  logic                   pop;
  logic [CHECKPOINTS-1:0] keepMask;  // All ones unless a checkpoint verifies

  assign inReady_o  = (count != 2'd2);
  assign outValid_o = (count != 2'd0);
  assign push       = inValid_i & inReady_o;
  assign pop        = outValid_o & outReady_i;
  assign keepMask   = ctrlVerified_i ? ~(CHECKPOINTS'(1) << ctrlVerifiedId_i) : '1;

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      wrPtr <= 1'b0;
      rdPtr <= 1'b0;
      count <= 2'd0;
    end else begin
      if (push) begin
        wrPtr <= ~wrPtr;
      end
      if (pop) begin
        rdPtr <= ~rdPtr;
      end
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    for (int e = 0; e < 2; e++) begin
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        branchMaskMem[e][i] <= branchMaskMem[e][i] & keepMask;  // Waiting bundles
      end
    end
    if (push) begin
      for (int i = 0; i < DISPATCH_WIDTH; i++) begin
        pcMem[wrPtr][i]          <= pc_i[i];
        logDestMem[wrPtr][i]     <= logDest_i[i];
        physDestMem[wrPtr][i]    <= physDest_i[i];
        oldPhysDestMem[wrPtr][i] <= oldPhysDest_i[i];
        physSrc1Mem[wrPtr][i]    <= physSrc1_i[i];
        operandMem[wrPtr][i]     <= operand_i[i];
        immValidMem[wrPtr][i]    <= immValid_i[i];
        branchMaskMem[wrPtr][i]  <= branchMask_i[i] & keepMask;  // Bundle being written
        isLoadMem[wrPtr][i]      <= isLoad_i[i];
        isStoreMem[wrPtr][i]     <= isStore_i[i];
      end
      loadCntMem[wrPtr]  <= loadCnt_i;
      storeCntMem[wrPtr] <= storeCnt_i;
    end
  end

  // Head bundle, mask also cleared for a verify in the cycle it leaves
  always_comb begin
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      pc_o[i]          = pcMem[rdPtr][i];
      logDest_o[i]     = logDestMem[rdPtr][i];
      physDest_o[i]    = physDestMem[rdPtr][i];
      oldPhysDest_o[i] = oldPhysDestMem[rdPtr][i];
      physSrc1_o[i]    = physSrc1Mem[rdPtr][i];
      operand_o[i]     = operandMem[rdPtr][i];
      immValid_o[i]    = immValidMem[rdPtr][i];
      branchMask_o[i]  = branchMaskMem[rdPtr][i] & keepMask;
      isLoad_o[i]      = isLoadMem[rdPtr][i];
      isStore_o[i]     = isStoreMem[rdPtr][i];
    end
    loadCnt_o  = loadCntMem[rdPtr];
    storeCnt_o = storeCntMem[rdPtr];
  end

endmodule
